// File: gb_host_io.f
+incdir+tests
hdl/gb_host_pkg.sv
hdl/download_tracker.sv
hdl/cheat_code_loader.sv
hdl/backup_sequencer.sv
hdl/backup_block_mux.sv
hdl/gb_host_io.sv
tests/tb_gb_host_io.sv

// File: hdl/backup_block_mux.sv
////////////////////////////////////////////////////////////////////////////
// Backup block mux
// Routes SD buffer traffic to backup RAM or to the RTC block
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module backup_block_mux
	import gb_host_pkg::*;
(
	input  logic [blk_num_w-1:0]  blk_num,
	input  logic [blk_num_w-1:0]  ram_last_blk,
	input  logic [buf_addr_w-1:0] sd_buff_addr,
	input  logic [io_word_w-1:0]  sd_buff_dout,
	input  logic                  sd_buff_wr,
	input  logic                  sd_ack,
	input  rtc_info_t             rtc,
	input  logic [io_word_w-1:0]  bk_q,
	output bk_port_t              bk_port,
	output logic                  rtc_wr,
	output logic [io_word_w-1:0]  sd_buff_din
);

	logic                 rtc_blk;
	logic [io_word_w-1:0] rtc_word;

	// Anything past the RAM image is the RTC block
	assign rtc_blk = blk_num > ram_last_blk;

	always_comb begin
		bk_port.addr = bk_addr_w'({blk_num, sd_buff_addr});
		bk_port.wr   = ~rtc_blk & sd_buff_wr & sd_ack;
		bk_port.data = sd_buff_dout;
	end

	assign rtc_wr = rtc_blk & sd_buff_wr & sd_ack;

	// Low word first, rest of the block is filler
	always_comb begin
		case (sd_buff_addr)
			buf_addr_w'(0): rtc_word = rtc.timestamp[15:0];
			buf_addr_w'(1): rtc_word = rtc.timestamp[31:16];
			buf_addr_w'(2): rtc_word = rtc.saved_time[15:0];
			buf_addr_w'(3): rtc_word = rtc.saved_time[31:16];
			buf_addr_w'(4): rtc_word = rtc.saved_time[47:32];
			default:        rtc_word = rtc_fill_word;
		endcase
	end

	assign sd_buff_din = rtc_blk ? rtc_word : bk_q;

endmodule

// File: hdl/backup_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// Backup RAM sequencer
// Save/load policy and the SD block walk over request/acknowledge
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module backup_sequencer
	import gb_host_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 cart_download,
	input  logic                 cart_done,
	input  logic                 img_mounted,
	input  logic                 img_readonly,
	input  logic                 img_size_nz,
	input  logic                 has_save,
	input  logic [blk_num_w-1:0] ram_last_blk,
	input  logic                 rtc_in_use,
	input  logic                 load_request,
	input  logic                 save_request,
	input  logic                 autosave_en,
	input  logic                 osd_open,
	input  logic                 cram_wr,
	input  logic                 sd_ack,
	output sd_req_t              sd_req,
	output logic                 busy,
	output logic                 core_hold,
	output logic                 save_pending
);

	logic cart_download_q;
	logic load_q;
	logic save_q;
	logic sd_ack_q;
	logic bk_ena;
	logic sav_supported;
	logic bk_save;
	logic load_rise;
	logic save_rise;
	logic ack_rise;
	logic ack_fall;
	logic user_start;
	logic auto_start;
	logic last_blk;

	assign sav_supported = has_save & bk_ena;

	// Manual save, or autosave once the menu opens with unsaved writes
	assign bk_save = save_request | (save_pending & osd_open & autosave_en);

	assign load_rise = load_request & ~load_q;
	assign save_rise = bk_save & ~save_q;
	assign ack_rise  = sd_ack & ~sd_ack_q;
	assign ack_fall  = ~sd_ack & sd_ack_q;

	assign user_start = ~busy & bk_ena & (load_rise | save_rise);
	assign auto_start = ~busy & bk_ena & cart_done & img_size_nz;

	// RTC adds one block past the RAM image
	assign last_blk = rtc_in_use ? (sd_req.blk[blk_num_w-1:0] > ram_last_blk) :
		(sd_req.blk[blk_num_w-1:0] >= ram_last_blk);

	////////////////////////////////////////////////////////////////////////////
	// Edge history and save policy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_download_q <= 1'b0;
			load_q          <= 1'b0;
			save_q          <= 1'b0;
			sd_ack_q        <= 1'b0;
		end else begin
			cart_download_q <= cart_download;
			load_q          <= load_request;
			save_q          <= bk_save;
			sd_ack_q        <= sd_ack;
		end
	end

	// Save image is mounted by the host near the end of the ROM download
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena <= 1'b0;
		end else if (cart_download & img_mounted & ~img_readonly) begin
			bk_ena <= 1'b1;
		end else if (cart_download & ~cart_download_q) begin
			bk_ena <= 1'b0;
		end
	end

	// Only game writes outside the menu count as unsaved data
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			save_pending <= 1'b0;
		end else if (busy | user_start | auto_start) begin
			save_pending <= 1'b0;
		end else if (cram_wr & ~osd_open & sav_supported) begin
			save_pending <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Block walk
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sd_req.rd <= 1'b0;
			sd_req.wr <= 1'b0;
			busy      <= 1'b0;
			core_hold <= 1'b0;
		end else begin
			// Host took the request
			if (ack_rise) begin
				sd_req.rd <= 1'b0;
				sd_req.wr <= 1'b0;
			end

			if (auto_start) begin
				busy       <= 1'b1;
				core_hold  <= 1'b1;
				sd_req.blk <= '0;
				sd_req.rd  <= 1'b1;
				sd_req.wr  <= 1'b0;
			end else if (user_start) begin
				busy       <= 1'b1;
				core_hold  <= load_rise;
				sd_req.blk <= '0;
				sd_req.rd  <= load_rise;
				sd_req.wr  <= ~load_rise;
			end else if (busy && ack_fall) begin
				if (last_blk) begin
					busy      <= 1'b0;
					core_hold <= 1'b0;
				end else begin
					// core_hold doubles as the direction of the transfer
					sd_req.blk <= sd_req.blk + sd_blk_w'(1);
					sd_req.rd  <= core_hold;
					sd_req.wr  <= ~core_hold;
				end
			end
		end
	end

endmodule

// File: hdl/cheat_code_loader.sv
////////////////////////////////////////////////////////////////////////////
// Cheat code loader
// Builds one code record from eight download words, offers it valid/ready
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module cheat_code_loader
	import gb_host_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  code_word_t  code_wr,
	output logic        cheat_valid,
	input  logic        cheat_ready,
	output cheat_code_t cheat_code,
	output logic        ioctl_wait
);

	cheat_code_t code_q;
	logic [2:0]  word_sel;
	logic        last_word;
	logic        accept;

	// Index 0 is the low half of flags, so pairs fill from the top slot down
	assign word_sel = {~code_wr.idx[2:1], code_wr.idx[0]};

	// Top half of the replace field closes the record
	assign last_word = code_wr.valid && (code_wr.idx == 3'd7);

	assign accept = cheat_valid & cheat_ready;

	always_ff @(posedge clk_sys) begin
		if (code_wr.valid) begin
			code_q.words[word_sel] <= code_wr.data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Handshake
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
		end else if (last_word) begin
			cheat_valid <= 1'b1;
		end else if (accept) begin
			cheat_valid <= 1'b0;
		end
	end

	assign cheat_code = code_q;

	// Host stalls while a finished record waits for the core
	assign ioctl_wait = cheat_valid & ~cheat_ready;

endmodule

// File: hdl/download_tracker.sv
////////////////////////////////////////////////////////////////////////////
// Download tracker
// Sorts host downloads by file type, flags cartridge download edges
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module download_tracker
	import gb_host_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 ioctl_download,
	input  logic [7:0]           ioctl_index,
	input  logic                 ioctl_wr,
	input  logic [io_addr_w-1:0] ioctl_addr,
	input  logic [io_word_w-1:0] ioctl_dout,
	output code_word_t           code_wr,
	output logic                 cart_download,
	output logic                 cart_done
);

	logic is_cart_type;
	logic is_code_type;
	logic cart_download_q;

	// All three ROM flavours land in the same cartridge space
	assign is_cart_type = (ioctl_index == ftype_cart_gb) ||
		(ioctl_index == ftype_cart_gbc) ||
		(ioctl_index == ftype_cart_alt);
	assign is_code_type = (ioctl_index == ftype_cheat);

	assign cart_download = ioctl_download & is_cart_type;

	// Word index from the byte address of a 16-bit word
	always_comb begin
		code_wr.valid = ioctl_download & is_code_type & ioctl_wr;
		code_wr.idx   = ioctl_addr[3:1];
		code_wr.data  = ioctl_dout;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_download_q <= 1'b0;
		end else begin
			cart_download_q <= cart_download;
		end
	end

	// End of a cartridge download
	assign cart_done = cart_download_q & ~cart_download;

endmodule

// File: hdl/gb_host_io.sv
////////////////////////////////////////////////////////////////////////////
// Host storage and download controller
// Download sorting, cheat loading and backup RAM save/load over SD
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module gb_host_io
	import gb_host_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	// Host download
	input  logic                  ioctl_download,
	input  logic [7:0]            ioctl_index,
	input  logic                  ioctl_wr,
	input  logic [io_addr_w-1:0]  ioctl_addr,
	input  logic [io_word_w-1:0]  ioctl_dout,
	output logic                  ioctl_wait,
	// Cheat record to the core
	output logic                  cheat_valid,
	input  logic                  cheat_ready,
	output cheat_code_t           cheat_code,
	// Save image and policy
	input  logic                  img_mounted,
	input  logic                  img_readonly,
	input  logic                  img_size_nz,
	input  logic                  has_save,
	input  logic [blk_num_w-1:0]  ram_last_blk,
	input  logic                  load_request,
	input  logic                  save_request,
	input  logic                  autosave_en,
	input  logic                  osd_open,
	input  logic                  cram_wr,
	// SD host
	input  logic                  sd_ack,
	output sd_req_t               sd_req,
	input  logic [buf_addr_w-1:0] sd_buff_addr,
	input  logic [io_word_w-1:0]  sd_buff_dout,
	input  logic                  sd_buff_wr,
	output logic [io_word_w-1:0]  sd_buff_din,
	// Backup RAM and RTC
	input  rtc_info_t             rtc,
	input  logic [io_word_w-1:0]  bk_q,
	output bk_port_t              bk_port,
	output logic                  rtc_wr,
	output logic                  busy,
	output logic                  core_hold,
	output logic                  save_pending
);

	code_word_t code_wr;
	logic       cart_download;
	logic       cart_done;

	download_tracker u_tracker (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.code_wr        (code_wr),
		.cart_download  (cart_download),
		.cart_done      (cart_done)
	);

	cheat_code_loader u_cheat (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.code_wr     (code_wr),
		.cheat_valid (cheat_valid),
		.cheat_ready (cheat_ready),
		.cheat_code  (cheat_code),
		.ioctl_wait  (ioctl_wait)
	);

	backup_sequencer u_seq (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.cart_done     (cart_done),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size_nz   (img_size_nz),
		.has_save      (has_save),
		.ram_last_blk  (ram_last_blk),
		.rtc_in_use    (rtc.in_use),
		.load_request  (load_request),
		.save_request  (save_request),
		.autosave_en   (autosave_en),
		.osd_open      (osd_open),
		.cram_wr       (cram_wr),
		.sd_ack        (sd_ack),
		.sd_req        (sd_req),
		.busy          (busy),
		.core_hold     (core_hold),
		.save_pending  (save_pending)
	);

	backup_block_mux u_mux (
		.blk_num      (sd_req.blk[blk_num_w-1:0]),
		.ram_last_blk (ram_last_blk),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_ack       (sd_ack),
		.rtc          (rtc),
		.bk_q         (bk_q),
		.bk_port      (bk_port),
		.rtc_wr       (rtc_wr),
		.sd_buff_din  (sd_buff_din)
	);

endmodule

// File: hdl/gb_host_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Host I/O package
// Widths, download file types and the record types shared by the host side
////////////////////////////////////////////////////////////////////////////
package gb_host_pkg;

	// Bus and address widths
	localparam int io_word_w  = 16;
	localparam int io_addr_w  = 25;
	localparam int blk_num_w  = 8;
	localparam int buf_addr_w = 8;
	localparam int sd_blk_w   = 32;
	localparam int bk_addr_w  = 17;

	// Download file types as sent by the host
	localparam logic [7:0] ftype_cart_gb  = 8'h01;
	localparam logic [7:0] ftype_cart_gbc = 8'h41;
	localparam logic [7:0] ftype_cart_alt = 8'h80;
	localparam logic [7:0] ftype_cheat    = 8'hFF;

	// Unused words of the RTC block
	localparam logic [io_word_w-1:0] rtc_fill_word = 16'hFFFF;

	////////////////////////////////////////////////////////////////////////////
	// Cheat codes
	////////////////////////////////////////////////////////////////////////////

	// One code word write from the download stream
	typedef struct packed {
		logic                 valid;
		logic [2:0]           idx;
		logic [io_word_w-1:0] data;
	} code_word_t;

	// Big endian fields, flags on top
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Filled as words, read by the core as fields
	typedef union packed {
		logic [7:0][io_word_w-1:0] words;
		cheat_fields_t             fields;
	} cheat_code_t;

	////////////////////////////////////////////////////////////////////////////
	// Backup RAM and SD
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [sd_blk_w-1:0] blk;
		logic                rd;
		logic                wr;
	} sd_req_t;

	typedef struct packed {
		logic [31:0] timestamp;
		logic [47:0] saved_time;
		logic        in_use;
	} rtc_info_t;

	typedef struct packed {
		logic [bk_addr_w-1:0] addr;
		logic                 wr;
		logic [io_word_w-1:0] data;
	} bk_port_t;

endpackage

// File: run_sim.sh
#!/bin/bash
# Build and run the gb_host_io testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module tb_gb_host_io \
	-f gb_host_io.f \
	-o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "Testbench reported failure"
	exit 1
fi

echo "Testbench run finished without failure"
exit 0

// File: tests/tb_checks.svh
////////////////////////////////////////////////////////////////////////////
// Testbench reference models and typed compare tasks
////////////////////////////////////////////////////////////////////////////
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Record as the core should see it from the words at download address 2*i
function automatic cheat_code_t expected_code(input logic [7:0][io_word_w-1:0] w);
	cheat_code_t c;
	c.fields.flags   = {w[1], w[0]};
	c.fields.address = {w[3], w[2]};
	c.fields.compare = {w[5], w[4]};
	c.fields.replace = {w[7], w[6]};
	return c;
endfunction

// Backup RAM contents that depend on every address bit
function automatic logic [io_word_w-1:0] ram_value(input logic [bk_addr_w-1:0] a);
	return a[15:0] ^ {a[16], a[16:2]} ^ 16'hA5C3;
endfunction

// Data the SD host streams into the core on a load
function automatic logic [io_word_w-1:0] host_word(input logic [7:0] blk,
	input logic [7:0] addr);
	return {blk ^ 8'h3C, addr} + 16'h1357;
endfunction

// Word the core must hand to the SD host on a save
function automatic logic [io_word_w-1:0] expected_din(input logic [7:0] blk,
	input logic [7:0] addr, input logic [7:0] last, input rtc_info_t r);
	logic [io_word_w-1:0] w;
	if (blk <= last) begin
		w = ram_value({1'b0, blk, addr});
	end else begin
		case (addr)
			8'd0: w = r.timestamp[15:0];
			8'd1: w = r.timestamp[31:16];
			8'd2: w = r.saved_time[15:0];
			8'd3: w = r.saved_time[31:16];
			8'd4: w = r.saved_time[47:32];
			default: w = 16'hFFFF;
		endcase
	end
	return w;
endfunction

task automatic check_code(input string name, input cheat_code_t got, input cheat_code_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAIL %s got %h expected %h", name, got, exp);
	end
endtask

task automatic check_word(input string name, input logic [io_word_w-1:0] got,
	input logic [io_word_w-1:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAIL %s got %h expected %h", name, got, exp);
	end
endtask

task automatic check_port(input string name, input bk_port_t got, input bk_port_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAIL %s got %h expected %h", name, got, exp);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAIL %s got %h expected %h", name, got, exp);
	end
endtask

`endif

// File: tests/tb_gb_host_io.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the host storage and download controller
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_gb_host_io
	import gb_host_pkg::*;
();

	localparam int total_blocks = 12;
	localparam int cycle_limit  = total_blocks * 600 + 2000;

	logic clk_sys = 1'b0;
	logic reset;
	logic ioctl_download, ioctl_wr, ioctl_wait, cheat_valid, cheat_ready;
	logic [7:0] ioctl_index;
	logic [io_addr_w-1:0] ioctl_addr;
	logic [io_word_w-1:0] ioctl_dout, sd_buff_dout, sd_buff_din, bk_q;
	cheat_code_t cheat_code;
	logic img_mounted, img_readonly, img_size_nz, has_save;
	logic [blk_num_w-1:0] ram_last_blk;
	logic load_request, save_request, autosave_en, osd_open, cram_wr;
	logic sd_ack, sd_buff_wr, rtc_wr, busy, core_hold, save_pending;
	sd_req_t sd_req;
	logic [buf_addr_w-1:0] sd_buff_addr;
	rtc_info_t rtc;
	bk_port_t bk_port;

	int checks = 0;
	int errors = 0;
	int err_mark = 0;
	int cycles = 0;
	int blocks_done;
	int records_got = 0;
	logic [7:0] next_blk;
	logic [7:0] req_blk;
	logic req_rd;
	logic exp_rd;
	logic xfer_on;
	cheat_code_t exp_codes[$];

	`include "tb_checks.svh"

	always #10 clk_sys = ~clk_sys;

	// Backup RAM returns a fixed pattern
	assign bk_q = ram_value(bk_port.addr);

	gb_host_io UUT (.*);

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Run stopped at the cycle limit before all tests finished");
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// SD host model
	////////////////////////////////////////////////////////////////////////////

	initial begin
		sd_ack = 1'b0;
		sd_buff_wr = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		xfer_on = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!reset && (sd_req.rd || sd_req.wr)) begin
				req_blk = sd_req.blk[7:0];
				req_rd = sd_req.rd;
				check_word("sd_req.blk", 16'(sd_req.blk), 16'(next_blk));
				check_word("sd_req.blk upper", sd_req.blk[31:16], 16'h0000);
				check_bit("sd_req.rd", sd_req.rd, exp_rd);
				check_bit("sd_req.wr", sd_req.wr, ~exp_rd);
				repeat ($urandom_range(12, 1)) @(posedge clk_sys);
				#2 sd_ack = 1'b1;
				for (int i = 0; i < 256; i++) begin
					@(posedge clk_sys);
					#2;
					sd_buff_addr = 8'(i);
					sd_buff_wr = req_rd;
					sd_buff_dout = host_word(req_blk, 8'(i));
					xfer_on = 1'b1;
				end
				@(posedge clk_sys);
				#2;
				sd_buff_wr = 1'b0;
				xfer_on = 1'b0;
				sd_ack = 1'b0;
				blocks_done++;
				next_blk++;
			end
		end
	end

	// Monitor for buffer traffic and accepted cheat records
	always @(negedge clk_sys) begin
		if (xfer_on) begin
			if (req_rd) begin
				check_bit("core_hold", core_hold, 1'b1);
				if (req_blk > ram_last_blk) begin
					check_bit("rtc_wr", rtc_wr, 1'b1);
					check_bit("bk_port.wr", bk_port.wr, 1'b0);
				end else begin
					check_bit("rtc_wr", rtc_wr, 1'b0);
					check_port("bk_port", bk_port,
						bk_port_t'{addr: {1'b0, req_blk, sd_buff_addr}, wr: 1'b1,
						data: host_word(req_blk, sd_buff_addr)});
				end
			end else begin
				check_bit("core_hold", core_hold, 1'b0);
				check_word("sd_buff_din", sd_buff_din,
					expected_din(req_blk, sd_buff_addr, ram_last_blk, rtc));
			end
		end
		if (cheat_valid && cheat_ready) begin
			if (exp_codes.size() == 0) begin
				errors++;
				$display("A cheat record was offered when none was expected");
			end else begin
				check_code("cheat_code", cheat_code, exp_codes.pop_front());
			end
			records_got++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic step(input int n = 1);
		repeat (n) @(posedge clk_sys);
		#2;
	endtask

	task automatic write_words(input logic [7:0] ftype, input logic [7:0][15:0] w);
		for (int i = 0; i < 8; i++) begin
			while (ioctl_wait) step();
			ioctl_index = ftype;
			ioctl_download = 1'b1;
			ioctl_addr = io_addr_w'(2 * i);
			ioctl_dout = w[i];
			ioctl_wr = 1'b1;
			step();
		end
		ioctl_wr = 1'b0;
		ioctl_download = 1'b0;
		step();
	endtask

	task automatic send_record();
		logic [7:0][15:0] w;
		for (int i = 0; i < 8; i++) w[i] = 16'($urandom);
		exp_codes.push_back(expected_code(w));
		write_words(ftype_cheat, w);
	endtask

	task automatic await_records(input int n);
		while (records_got < n) step();
	endtask

	// Waits for one whole save or load to start and to finish
	task automatic await_transfer(input int n);
		do @(negedge clk_sys); while (!busy);
		do @(negedge clk_sys); while (busy);
		check_word("block count", 16'(blocks_done), 16'(n));
		check_bit("core_hold", core_hold, 1'b0);
		step();
	endtask

	task automatic arm_transfer(input logic rd);
		exp_rd = rd;
		next_blk = '0;
		blocks_done = 0;
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hb94f_1682));
		reset = 1'b1;
		{ioctl_download, ioctl_wr, cheat_ready, img_mounted, img_readonly} = '0;
		{load_request, save_request, autosave_en, osd_open, cram_wr} = '0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		img_size_nz = 1'b1;
		has_save = 1'b1;
		ram_last_blk = 8'd1;
		rtc = '0;
		arm_transfer(1'b1);
		repeat (5) @(posedge clk_sys);
		#2 reset = 1'b0;
		step();
		check_bit("cheat_valid", cheat_valid, 1'b0);
		check_bit("ioctl_wait", ioctl_wait, 1'b0);
		check_bit("sd_req.rd", sd_req.rd, 1'b0);
		check_bit("sd_req.wr", sd_req.wr, 1'b0);
		check_bit("busy", busy, 1'b0);
		check_bit("core_hold", core_hold, 1'b0);
		check_bit("save_pending", save_pending, 1'b0);

		cheat_ready = 1'b1;
		send_record();
		await_records(1);
		end_test("cheat assembly");

		cheat_ready = 1'b0;
		send_record();
		while (!cheat_valid) step();
		step(3);
		check_bit("ioctl_wait", ioctl_wait, 1'b1);
		check_bit("cheat_valid", cheat_valid, 1'b1);
		cheat_ready = 1'b1;
		await_records(2);
		// A stray record would stay offered while the core is not ready
		cheat_ready = 1'b0;
		write_words(8'h02, {8{16'h1234}});
		check_bit("cheat_valid", cheat_valid, 1'b0);
		cheat_ready = 1'b1;
		send_record();
		await_records(3);
		end_test("cheat back-pressure");

		arm_transfer(1'b1);
		ioctl_index = ftype_cart_gb;
		ioctl_download = 1'b1;
		step();
		img_mounted = 1'b1;
		step(3);
		img_mounted = 1'b0;
		step(4);
		ioctl_download = 1'b0;
		await_transfer(2);
		end_test("load after download");

		arm_transfer(1'b0);
		save_request = 1'b1;
		step();
		save_request = 1'b0;
		await_transfer(2);
		end_test("manual save");

		rtc.in_use = 1'b1;
		rtc.timestamp = $urandom;
		rtc.saved_time = {16'($urandom), 32'($urandom)};
		arm_transfer(1'b1);
		load_request = 1'b1;
		step();
		load_request = 1'b0;
		await_transfer(3);
		arm_transfer(1'b0);
		save_request = 1'b1;
		step();
		save_request = 1'b0;
		await_transfer(3);
		rtc.in_use = 1'b0;
		end_test("rtc block");

		autosave_en = 1'b1;
		cram_wr = 1'b1;
		step();
		cram_wr = 1'b0;
		step();
		check_bit("save_pending", save_pending, 1'b1);
		arm_transfer(1'b0);
		osd_open = 1'b1;
		do @(negedge clk_sys); while (!busy);
		check_bit("save_pending", save_pending, 1'b0);
		await_transfer(2);
		osd_open = 1'b0;
		end_test("autosave");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
